//--- logic/rs_pkg.sv
/*
  Shared widths, frame constants and coefficient tables for the 3/4
  polyphase resampler. Modules import it inside their bodies.
*/
package rs_pkg;

  // **************************************************
  // Word widths
  // **************************************************
  localparam int SAMPLE_W    = 8;          // Input sample width
  localparam int RESULT_W    = 9;          // Phase result and output width
  localparam int COEF_W      = 9;          // Sinc coefficient width
  localparam int ACC_W       = 18;         // Product sum, full-scale safe
  localparam int SCALE_SHIFT = 8;          // Coefficients scaled by 256

  // **************************************************
  // Frame constants
  // **************************************************
  localparam int NUM_TAPS          = 11;   // Filter length
  localparam int SAMPLES_PER_FRAME = 4;    // Inputs per frame
  localparam int FRAME_LEN         = 12;   // Clock cycles per frame
  localparam int OUT_SPACING       = 4;    // Cycles between output strobes
  localparam int CENTER_TAP        = 5;    // Pure delay phase tap
  localparam int CNT_W   = $clog2(FRAME_LEN);    // Frame counter width
  localparam int SPACE_W = $clog2(OUT_SPACING);  // Spacing counter width

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [RESULT_W-1:0] result_t;
  typedef logic signed [COEF_W-1:0]   coef_t;

  typedef sample_t tap_vec_t  [0:NUM_TAPS-1];  // Tap 0 is newest
  typedef coef_t   coef_vec_t [0:NUM_TAPS-1];

  // Early sinc phase, tap 0 first
  localparam coef_vec_t PHASE0_COEF = '{
    -9'sd19,  9'sd26, -9'sd42,  9'sd106, 9'sd212, -9'sd53,
     9'sd29, -9'sd21,  9'sd16, -9'sd13,  9'sd11
  };

  // Late phase, mirror of the early one
  localparam coef_vec_t PHASE2_COEF = '{
     9'sd11, -9'sd13,  9'sd16, -9'sd21,  9'sd29, -9'sd53,
     9'sd212, 9'sd106, -9'sd42, 9'sd26, -9'sd19
  };

endpackage

//--- logic/rs_ifaces.sv
/*
  Internal buses of the resampler. frame_if carries the gathered
  samples and the tap vector, phase_if the three phase results.
*/
`timescale 1ns/100ps

interface frame_if;
  import rs_pkg::*;

  sample_t  gathered [0:SAMPLES_PER_FRAME-1]; // Newest at index 0
  logic     frame_load;                       // Frame complete, load taps
  tap_vec_t taps;                             // Current tap line
  logic     taps_valid;                       // Taps just reloaded

  modport seq    (output frame_load);         // Frame sequencer side
  modport gather (output gathered);           // Input buffer side

  modport tapline (input  gathered,
                   input  frame_load,
                   output taps,
                   output taps_valid);

  modport bank   (input  taps,
                  input  taps_valid);

endinterface

interface phase_if;
  import rs_pkg::*;

  result_t early;       // Sinc phase 0
  result_t center;      // Delay phase
  result_t late;        // Sinc phase 2
  logic    phase_valid; // All three results fresh

  modport source (output early, output center, output late, output phase_valid);
  modport sink   (input  early, input  center, input  late, input  phase_valid);

endinterface

//--- logic/rate_sequencer.sv
/*
  Frame sequencer. Counts the 12-cycle frame, opens an input slot every
  third cycle and waits there for a sample. Pulses frame_load once the
  fourth sample of a frame is accepted.
*/
`timescale 1ns/100ps

module rate_sequencer
(
  input  logic clk,
  input  logic reset,
  input  logic x_valid_i,     // Upstream offers a sample
  output logic x_ready_o,     // Input slot open
  output logic accept_o,      // Sample transfers this edge
  frame_if.seq frame
);
  import rs_pkg::*;

  logic [CNT_W-1:0] count;    // Frame position 0..11
  logic             slot;     // Count sits on an input slot
  logic             last;     // Final cycle of the frame
  logic             advance;  // Count moves this edge

  // **************************************************
  // Slot decode
  // **************************************************
  always_comb
  begin
    case (count)
      4'd2, 4'd5, 4'd8, 4'd11: slot = 1'b1;  // One slot per 3 cycles
      default:                 slot = 1'b0;
    endcase
  end

  assign last      = (count == CNT_W'(FRAME_LEN - 1));
  assign x_ready_o = slot;                  // From count only
  assign accept_o  = slot & x_valid_i;      // Handshake made here once
  assign advance   = ~slot | x_valid_i;     // Hold at a starved slot

  // **************************************************
  // Frame counter and load pulse
  // **************************************************
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count            <= '0;
      frame.frame_load <= 1'b0;
    end
    else
    begin
      frame.frame_load <= last & accept_o;  // Fourth sample taken
      if (advance)
      begin
        if (last)
          count <= '0;                      // Wrap at end of frame
        else
          count <= count + 1'b1;
      end
    end
  end

endmodule

//--- logic/input_gather.sv
/*
  Input gatherer. Shifts one sample in per accepted handshake and shows
  the four most recent samples, newest first, to the tap line.
*/
`timescale 1ns/100ps

module input_gather
(
  input  logic           clk,
  input  logic           reset,
  input  logic           accept_i,  // Handshake from sequencer
  input  rs_pkg::sample_t x_i,      // Offered sample
  frame_if.gather        frame
);
  import rs_pkg::*;

  sample_t gbuf [0:SAMPLES_PER_FRAME-1];  // Gather shift buffer

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < SAMPLES_PER_FRAME; i++)
      begin
        gbuf[i] <= '0;                    // Clear all entries
      end
    end
    else if (accept_i)
    begin
      for (int i = SAMPLES_PER_FRAME - 1; i > 0; i--)
      begin
        gbuf[i] <= gbuf[i-1];             // Age by one
      end
      gbuf[0] <= x_i;                     // Newest in front
    end
  end

  // Present buffer to the tap line
  always_comb
  begin
    for (int i = 0; i < SAMPLES_PER_FRAME; i++)
    begin
      frame.gathered[i] = gbuf[i];
    end
  end

endmodule

//--- logic/tap_line.sv
/*
  Eleven-tap delay line. On each frame load the four gathered samples
  enter at taps 0..3 and the older taps move down by four.
*/
`timescale 1ns/100ps

module tap_line
(
  input  logic     clk,
  input  logic     reset,
  frame_if.tapline frame
);
  import rs_pkg::*;

  tap_vec_t tap_q;                          // Tap registers, 0 newest

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_TAPS; i++)
      begin
        tap_q[i] <= '0;
      end
      frame.taps_valid <= 1'b0;
    end
    else
    begin
      frame.taps_valid <= frame.frame_load; // One cycle behind load
      if (frame.frame_load)
      begin
        for (int i = 0; i < SAMPLES_PER_FRAME; i++)
        begin
          tap_q[i] <= frame.gathered[i];    // New block of four
        end
        for (int i = SAMPLES_PER_FRAME; i < NUM_TAPS; i++)
        begin
          tap_q[i] <= tap_q[i-SAMPLES_PER_FRAME];  // 0->4, 4->8 etc.
        end
      end
    end
  end

  assign frame.taps = tap_q;

endmodule

//--- logic/polyphase_bank.sv
/*
  Polyphase bank. Two 11-tap sum-of-products sinc phases and the
  center-tap delay phase, registered together on the cycle after the
  tap line reloads.
*/
`timescale 1ns/100ps

module polyphase_bank
(
  input  logic    clk,
  input  logic    reset,
  frame_if.bank   frame,
  phase_if.source phase
);
  import rs_pkg::*;

  logic signed [ACC_W-1:0] acc_early;   // Phase 0 product sum
  logic signed [ACC_W-1:0] acc_late;    // Phase 2 product sum
  result_t                 early_d;     // Scaled and truncated
  result_t                 late_d;
  result_t                 center_d;    // Delay phase, no scaling

  // **************************************************
  // Sum of products
  // **************************************************
  always_comb
  begin
    acc_early = '0;
    acc_late  = '0;
    for (int i = 0; i < NUM_TAPS; i++)
    begin
      acc_early = acc_early
                + ACC_W'(PHASE0_COEF[i]) * ACC_W'(frame.taps[i]);  // Signed MAC
      acc_late  = acc_late
                + ACC_W'(PHASE2_COEF[i]) * ACC_W'(frame.taps[i]);
    end
  end

  // Divide by 256, then keep the low result bits
  assign early_d  = result_t'(acc_early >>> SCALE_SHIFT);
  assign late_d   = result_t'(acc_late >>> SCALE_SHIFT);
  assign center_d = result_t'(frame.taps[CENTER_TAP]);  // Sign extend

  // **************************************************
  // Result registers
  // **************************************************
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase.early       <= '0;
      phase.center      <= '0;
      phase.late        <= '0;
      phase.phase_valid <= 1'b0;
    end
    else
    begin
      phase.phase_valid <= frame.taps_valid;  // Strobe with the results
      if (frame.taps_valid)
      begin
        phase.early  <= early_d;
        phase.center <= center_d;
        phase.late   <= late_d;
      end
    end
  end

endmodule

//--- logic/output_serializer.sv
/*
  Output serializer. Loads the three phase results, emits the late one
  at once, then center and early each OUT_SPACING cycles later, each
  with a single-cycle valid strobe.
*/
`timescale 1ns/100ps

module output_serializer
(
  input  logic            clk,
  input  logic            reset,
  phase_if.sink           phase,
  output rs_pkg::result_t y_o,        // Current output sample
  output logic            y_valid_o   // One-cycle strobe per sample
);
  import rs_pkg::*;

  result_t            obuf [0:2];     // 0 late, 1 center, 2 early
  logic [1:0]         pending;        // Results still to strobe
  logic [SPACE_W-1:0] space_cnt;      // Cycles to next strobe

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 3; i++)
      begin
        obuf[i] <= '0;
      end
      pending   <= '0;
      space_cnt <= '0;
      y_valid_o <= 1'b0;
    end
    else if (phase.phase_valid)
    begin
      obuf[0]   <= phase.late;          // Shown immediately
      obuf[1]   <= phase.center;
      obuf[2]   <= phase.early;
      pending   <= 2'd2;
      space_cnt <= SPACE_W'(OUT_SPACING - 1);
      y_valid_o <= 1'b1;
    end
    else if ((pending != 2'd0) && (space_cnt == '0))
    begin
      obuf[0]   <= obuf[1];             // Shift toward output
      obuf[1]   <= obuf[2];
      pending   <= pending - 1'b1;
      space_cnt <= SPACE_W'(OUT_SPACING - 1);
      y_valid_o <= 1'b1;
    end
    else
    begin
      if (pending != 2'd0)
        space_cnt <= space_cnt - 1'b1;  // Wait out the spacing
      y_valid_o <= 1'b0;
    end
  end

  assign y_o = obuf[0];

endmodule

//--- logic/rc_resampler_top.sv
/*
  Top level of the 3/4 polyphase sinc resampler. Four samples in per
  12-cycle frame over valid/ready, three strobed results out.
*/
`timescale 1ns/100ps

module rc_resampler_top
(
  input  logic            clk,
  input  logic            reset,          // Asynchronous, active high
  input  rs_pkg::sample_t x_i,            // Input sample
  input  logic            x_valid_i,
  output logic            x_ready_o,
  output rs_pkg::result_t y_o,            // Output sample
  output logic            y_valid_o
);

  logic    accept;                        // Input transfer this edge
  frame_if frame_bus ();                  // Gather, taps, load controls
  phase_if phase_bus ();                  // Phase results

  rate_sequencer rate_sequencer_inst
  (
    .clk       (clk),
    .reset     (reset),
    .x_valid_i (x_valid_i),
    .x_ready_o (x_ready_o),
    .accept_o  (accept),
    .frame     (frame_bus.seq)
  );

  input_gather input_gather_inst
  (
    .clk      (clk),
    .reset    (reset),
    .accept_i (accept),
    .x_i      (x_i),
    .frame    (frame_bus.gather)
  );

  tap_line tap_line_inst
  (
    .clk   (clk),
    .reset (reset),
    .frame (frame_bus.tapline)
  );

  polyphase_bank polyphase_bank_inst
  (
    .clk   (clk),
    .reset (reset),
    .frame (frame_bus.bank),
    .phase (phase_bus.source)
  );

  output_serializer output_serializer_inst
  (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase_bus.sink),
    .y_o       (y_o),
    .y_valid_o (y_valid_o)
  );

endmodule

//--- tb/rc_resampler_tb.sv
/*
  Testbench for the 3/4 polyphase resampler. Applies a table of samples
  and idle gaps, models the frame count, tap line and phases, and checks
  every output strobe for value and edge.
*/
`timescale 1ns/100ps

module rc_resampler_tb;
  import rs_pkg::*;

  logic    clk;
  logic    reset;
  sample_t x_i;
  logic    x_valid_i;
  logic    x_ready_o;
  result_t y_o;
  logic    y_valid_o;

  sample_t stim_val  [$];              // Stimulus table, sample column
  int      stim_gap  [$];              // Idle cycles before the sample
  string   stim_name [$];              // Section name

  result_t exp_val  [$];               // Expected outputs, in order
  int      exp_edge [$];               // Rising edge that raises the strobe
  string   exp_name [$];

  sample_t ref_taps  [0:NUM_TAPS-1];          // Model tap line, 0 newest
  sample_t frame_buf [0:SAMPLES_PER_FRAME-1]; // Accepted samples, oldest first
  int      taken_cnt;                  // Samples accepted so far
  int      exp_count;                  // Model of the frame count
  int      cycle;                      // Rising edges since reset release
  int      cycle_limit;                // Timeout in cycles
  int      total_gap;                  // Sum of all table gaps
  int      last_edge;                  // Edge of the final expected strobe
  integer  seed;

  rc_resampler_top rc_resampler_top_inst
  (
    .clk       (clk),
    .reset     (reset),
    .x_i       (x_i),
    .x_valid_i (x_valid_i),
    .x_ready_o (x_ready_o),
    .y_o       (y_o),
    .y_valid_o (y_valid_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;            // 40 ns period
  end

  // **************************************************
  // Failure reporting and compare tasks
  // **************************************************
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp)
      fail_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (act != exp)
      fail_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_reset_state(input string name);
    check_flag({name, " y_valid_o"}, 1'b0, y_valid_o);
    check_flag({name, " x_ready_o"}, 1'b0, x_ready_o);
    check_result({name, " y_o"}, '0, y_o);
  endtask

  // **************************************************
  // Stimulus table
  // **************************************************
  task automatic add_stim(input sample_t val, input int gap, input string name);
    stim_val.push_back(val);
    stim_gap.push_back(gap);
    stim_name.push_back(name);
    total_gap = total_gap + gap;
  endtask

  task automatic build_table();
    int stall_gap [0:7] = '{3, 0, 5, 1, 7, 2, 4, 6};  // Over 2 starves a slot
    for (int k = 0; k < 12; k++)
    begin
      // Third sample of a frame passes the center tap one frame later
      add_stim((k == 2) ? sample_t'(127) : sample_t'(0), 0, "impulse");
    end
    for (int k = 0; k < 16; k++)
    begin
      add_stim(((k / 4) % 2 == 0) ? sample_t'(-128) : sample_t'(127), 0, "full_scale");
    end
    for (int k = 0; k < 16; k++)
    begin
      add_stim(sample_t'($random(seed)), 0, "random");
    end
    for (int k = 0; k < 8; k++)
    begin
      add_stim(sample_t'($random(seed)), stall_gap[k], "stall");
    end
  endtask

  // **************************************************
  // Reference model
  // **************************************************
  function automatic logic slot_open(input int cnt);
    return (cnt == 2) || (cnt == 5) || (cnt == 8) || (cnt == 11);
  endfunction

  task automatic model_frame(input int accept_edge, input string name);
    int      acc_early;
    int      acc_late;
    result_t early;
    result_t center;
    result_t late;
    for (int i = NUM_TAPS - 1; i >= SAMPLES_PER_FRAME; i--)
    begin
      ref_taps[i] = ref_taps[i - SAMPLES_PER_FRAME];      // Old block moves by four
    end
    for (int i = 0; i < SAMPLES_PER_FRAME; i++)
    begin
      ref_taps[i] = frame_buf[SAMPLES_PER_FRAME - 1 - i]; // Newest at tap 0
    end
    acc_early = 0;
    acc_late  = 0;
    for (int i = 0; i < NUM_TAPS; i++)
    begin
      acc_early = acc_early + int'(PHASE0_COEF[i]) * int'(ref_taps[i]);
      acc_late  = acc_late + int'(PHASE2_COEF[i]) * int'(ref_taps[i]);
    end
    early  = result_t'(acc_early >>> SCALE_SHIFT);  // Scale, then truncate
    late   = result_t'(acc_late >>> SCALE_SHIFT);
    center = result_t'(ref_taps[CENTER_TAP]);       // Pure delay
    // Late first, 3 edges after the accept, then every OUT_SPACING
    exp_val.push_back(late);
    exp_edge.push_back(accept_edge + 3);
    exp_name.push_back({name, " late"});
    exp_val.push_back(center);
    exp_edge.push_back(accept_edge + 3 + OUT_SPACING);
    exp_name.push_back({name, " center"});
    exp_val.push_back(early);
    exp_edge.push_back(accept_edge + 3 + 2 * OUT_SPACING);
    exp_name.push_back({name, " early"});
    last_edge = accept_edge + 3 + 2 * OUT_SPACING;
  endtask

  // **************************************************
  // Driver
  // **************************************************
  task automatic drive_cycle(input logic valid, input sample_t val, output logic taken);
    @(negedge clk);
    x_valid_i = valid;
    x_i       = val;
    check_flag($sformatf("x_ready_o at count %0d", exp_count), slot_open(exp_count), x_ready_o);
    taken = valid & slot_open(exp_count);           // Transfer on next rise
    if (!slot_open(exp_count) || valid)
      exp_count = (exp_count + 1) % FRAME_LEN;      // Holds at a starved slot
  endtask

  task automatic offer_entry(input int idx);
    logic taken;
    repeat (stim_gap[idx])
    begin
      drive_cycle(1'b0, '0, taken);
    end
    taken = 1'b0;
    while (!taken)
    begin
      drive_cycle(1'b1, stim_val[idx], taken);
    end
    frame_buf[taken_cnt % SAMPLES_PER_FRAME] = stim_val[idx];
    taken_cnt++;
    if (taken_cnt % SAMPLES_PER_FRAME == 0)
      model_frame(cycle + 1, stim_name[idx]);       // Accept edge is the next rise
  endtask

  // **************************************************
  // Cycle counter, timeout and output monitor
  // **************************************************
  always @(posedge clk or posedge reset)
  begin
    if (reset)
      cycle <= 0;
    else
    begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit)
        fail_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  always @(negedge clk)
  begin
    if (cycle > 0)
    begin
      if (y_valid_o)
      begin
        if (exp_val.size() == 0)
          fail_run("Output strobe seen while no result was expected");
        else
        begin
          check_cycle({exp_name[0], " strobe edge"}, exp_edge[0], cycle);
          check_result(exp_name[0], exp_val[0], y_o);
          void'(exp_val.pop_front());
          void'(exp_edge.pop_front());
          void'(exp_name.pop_front());
        end
      end
      else if ((exp_edge.size() != 0) && (cycle >= exp_edge[0]))
        check_flag({exp_name[0], " y_valid_o"}, 1'b1, y_valid_o);  // Missed strobe
    end
  end

  // **************************************************
  // Main sequence
  // **************************************************
  initial
  begin
    logic idle_taken;
    seed       = 32'hfc6b_1c92;
    reset      = 1'b1;
    x_i        = '0;
    x_valid_i  = 1'b0;
    taken_cnt  = 0;
    exp_count  = 0;
    total_gap  = 0;
    last_edge  = 0;
    for (int i = 0; i < NUM_TAPS; i++)
    begin
      ref_taps[i] = '0;
    end
    build_table();
    cycle_limit = FRAME_LEN * (stim_val.size() / SAMPLES_PER_FRAME) + total_gap + 50;

    @(negedge clk);
    check_reset_state("during reset");
    @(negedge clk);
    reset = 1'b0;                      // Released after 2 rising edges
    check_reset_state("after reset");
    exp_count = 1;                     // Count leaves 0 on the next rise

    for (int n = 0; n < stim_val.size(); n++)
    begin
      offer_entry(n);
    end

    // Idle until the last strobe plus margin for stray strobes
    while (cycle < last_edge + 2 * OUT_SPACING)
    begin
      drive_cycle(1'b0, '0, idle_taken);
    end

    if (exp_val.size() != 0)
      fail_run($sformatf("%0d expected outputs never appeared", exp_val.size()));
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- all.f
logic/rs_pkg.sv
logic/rs_ifaces.sv
logic/rate_sequencer.sv
logic/input_gather.sv
logic/tap_line.sv
logic/polyphase_bank.sv
logic/output_serializer.sv
logic/rc_resampler_top.sv
tb/rc_resampler_tb.sv

//--- run.sh
#!/bin/sh
# Build the resampler testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module rc_resampler_tb \
  -f all.f \
  -o rc_resampler_sim

# tee keeps the pipeline status at zero so the log decides the verdict
./obj_dir/rc_resampler_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
